//--- program.hex
// bubble sort of 8 words, one instruction per line, word index is pc[9:2]
// after the ecall every remaining word up to index 255 is a nop
00000513 // addi x10, x0, 0    array base
00800593 // addi x11, x0, 8    n
00000293 // addi x5, x0, 0     i
00000313 // addi x6, x0, 0     j, outer loop
405583b3 // sub x7, x11, x5
fff38393 // addi x7, x7, -1    last j
02730463 // beq x6, x7, +40    inner loop
00231e13 // slli x28, x6, 2
00ae0e33 // add x28, x28, x10
000e2e83 // lw x29, 0(x28)
004e2f03 // lw x30, 4(x28)
01eec663 // blt x29, x30, +12
01ee2023 // sw x30, 0(x28)     swap
01de2223 // sw x29, 4(x28)
00130313 // addi x6, x6, 1
fddff06f // jal x0, -36
00128293 // addi x5, x5, 1
fcb2c4e3 // blt x5, x11, -56
00000073 // ecall, end of program
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013

//--- project.f
logic/rvPkg.sv
logic/instructionMemory.sv
logic/fetchStage.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/frontEnd.sv
testbench/frontEnd_props.sv
testbench/frontEndTb.sv

//--- testbench/frontEndTb.sv
`timescale 1ns/1ns

module frontEndTb;

    localparam int resetCycles   = 16;
    localparam int runCycles     = 600;
    localparam int timeoutCycles = 1000;    // reset plus run, with margin

    logic               clk;
    logic               rstN;
    rvPkg::redirectT    redirect;
    logic               stallF;
    logic               stallD;
    logic               flushD;
    rvPkg::writebackT   wb;
    logic [31:0]        pcF;
    rvPkg::decodeOutT   decodeOut;

    logic [31:0] lfsr = 32'h83cf_81f5;
    logic [31:0] prog [0:255];      // own copy of the ROM image
    logic [31:0] mRegs [0:31];      // model register file
    logic [31:0] mPc;               // model fetch pc
    logic [31:0] mInstr;            // model fetch-to-decode register
    logic [31:0] mPcD;
    logic [31:0] mPcPlus4D;
    logic        mValid;
    int          errorCount = 0;
    int          cycleCount = 0;

    frontEnd uut (
        .clk       (clk),
        .rstN      (rstN),
        .redirect  (redirect),
        .stallF    (stallF),
        .stallD    (stallD),
        .flushD    (flushD),
        .wb        (wb),
        .pcF       (pcF),
        .decodeOut (decodeOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] expectedImm(input logic [31:0] w);
        case (w[6:0])
            rvPkg::opStore:  return {{20{w[31]}}, w[31:25], w[11:7]};
            rvPkg::opBranch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rvPkg::opJal:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:         return {{20{w[31]}}, w[31:20]};   // I layout
        endcase
    endfunction

    // {regWrite, memWrite, branch, jump, aluSrc, illegal, resultSrc, aluControl}
    function automatic logic [10:0] expectedControls(input logic [31:0] w, input logic valid);
        logic       rw, mw, br, jp, src, ill;
        logic [1:0] res;
        logic [2:0] alu;
        {rw, mw, br, jp, src, ill} = '0;
        res = rvPkg::resAluResult;
        alu = rvPkg::aluAdd;
        case (w[6:0])
            rvPkg::opOpImm: begin
                {rw, src} = 2'b11;
                if (w[14:12] == 3'b001) alu = rvPkg::aluSll;   // slli
            end
            rvPkg::opOp: begin
                rw = 1'b1;
                if (w[30]) alu = rvPkg::aluSub;                // funct7 bit 5
            end
            rvPkg::opLoad: begin
                {rw, src} = 2'b11;
                res = rvPkg::resMemData;
            end
            rvPkg::opStore: {mw, src} = 2'b11;
            rvPkg::opBranch: begin
                br  = 1'b1;
                alu = (w[14:12] == 3'b100) ? rvPkg::aluLessThan : rvPkg::aluSub;
            end
            rvPkg::opJal: begin
                {jp, rw} = 2'b11;
                res = rvPkg::resPcPlus4;
            end
            default: ill = 1'b1;
        endcase
        return {rw & valid, mw & valid, br & valid, jp & valid, src, ill, res, alu};
    endfunction

    function automatic logic [31:0] expectedRead(input logic [4:0] rs);
        if (rs == 5'd0) return '0;
        if (wb.regWrite && wb.rd == rs) return wb.result;  // same-cycle write
        return mRegs[rs];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // one rising edge of the model
    task automatic updateModel();
        if (wb.regWrite && wb.rd != 5'd0) mRegs[wb.rd] = wb.result;
        if (flushD) begin
            mInstr    = rvPkg::nopWord;
            mPcD      = '0;
            mPcPlus4D = '0;
            mValid    = 1'b0;
        end else if (!stallD) begin
            mInstr    = prog[mPc[9:2]];
            mPcD      = mPc;
            mPcPlus4D = mPc + 32'd4;
            mValid    = 1'b1;
        end
        if (!stallF) mPc = redirect.pcSrc ? redirect.target : mPc + 32'd4;
    endtask

    task automatic driveInputs();
        int pick;
        stallF          = (takeBits(3) == 0);       // about one in eight
        stallD          = (takeBits(3) == 0);
        flushD          = (takeBits(3) == 0);
        redirect.pcSrc  = (takeBits(8) < 43);       // about one in six
        redirect.target = takeBits(8) << 2;         // word aligned, below 1024
        wb.regWrite     = takeBits(1);
        pick            = takeBits(2);
        // aim at the live source fields often, to hit the bypass
        wb.rd     = (pick == 0) ? mInstr[19:15] : (pick == 1) ? mInstr[24:20] : takeBits(5);
        wb.result = takeBits(32);
    endtask

    task automatic checkOutputs();
        checkValue("pcF", mPc, pcF);
        checkValue("decodeOut.valid", mValid, decodeOut.valid);
        checkValue("decodeOut.pc", mPcD, decodeOut.pc);
        checkValue("decodeOut.pcPlus4", mPcPlus4D, decodeOut.pcPlus4);
        checkValue("decodeOut.immExt", expectedImm(mInstr), decodeOut.immExt);
        checkValue("decodeOut controls", expectedControls(mInstr, mValid),
                   {decodeOut.regWrite, decodeOut.memWrite, decodeOut.branch, decodeOut.jump,
                    decodeOut.aluSrc, decodeOut.illegal, decodeOut.resultSrc,
                    decodeOut.aluControl});
        checkValue("decodeOut funct3/rs1/rs2/rd",
                   {mInstr[14:12], mInstr[19:15], mInstr[24:20], mInstr[11:7]},
                   {decodeOut.funct3, decodeOut.rs1, decodeOut.rs2, decodeOut.rd});
        checkValue("decodeOut.rd1", expectedRead(mInstr[19:15]), decodeOut.rd1);
        checkValue("decodeOut.rd2", expectedRead(mInstr[24:20]), decodeOut.rd2);
    endtask

    initial begin
        rstN     = 1'b0;
        stallF   = 1'b0;
        stallD   = 1'b0;
        flushD   = 1'b0;
        redirect = '0;
        wb       = '0;
        $readmemh("program.hex", prog);
        for (int i = 0; i < 32; i++) mRegs[i] = '0;
        mPc       = '0;                 // reset state of the model
        mInstr    = rvPkg::nopWord;
        mPcD      = '0;
        mPcPlus4D = '0;
        mValid    = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        repeat (runCycles) begin
            @(posedge clk);
            updateModel();
            @(negedge clk);
            driveInputs();
            #2;                         // let the read bypass settle
            checkOutputs();
        end
        $display("closing: %0d compare errors, %0d assertion errors",
                 errorCount, uut.props.failCount);
        if (errorCount + uut.props.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not end within %0d cycles", timeoutCycles);
        $display("Something failed");
        $finish;
    end

endmodule

//--- testbench/frontEnd_props.sv
`timescale 1ns/1ns

module frontEndProps (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvPkg::redirectT        redirect,
    input  logic                   stallF,
    input  logic [rvPkg::xlen-1:0] pcF,
    input  rvPkg::decodeOutT       decodeOut
);

    int failCount = 0;  // summed into the closing line by the testbench

    // boot state, seen one edge after any reset edge
    resetState: assert property (@(posedge clk)
        !rstN |=> (pcF == '0) && !decodeOut.valid && !decodeOut.regWrite &&
                  !decodeOut.memWrite && !decodeOut.branch && !decodeOut.jump)
        else begin
            failCount++;
            $error("pc or decode enables not cleared after reset");
        end

    pcHold: assert property (@(posedge clk) disable iff (!rstN)
        stallF |=> pcF == $past(pcF))
        else begin
            failCount++;
            $error("pc moved while fetch was stalled");
        end

    pcRedirect: assert property (@(posedge clk) disable iff (!rstN)
        !stallF && redirect.pcSrc |=> pcF == $past(redirect.target))
        else begin
            failCount++;
            $error("pc did not take the redirect target");
        end

    pcSequential: assert property (@(posedge clk) disable iff (!rstN)
        !stallF && !redirect.pcSrc |=> pcF == $past(pcF) + 32'd4)
        else begin
            failCount++;
            $error("pc did not advance by one word");
        end

    // a bubble in decode never writes or redirects
    bubbleQuiet: assert property (@(posedge clk)
        !decodeOut.valid |-> !(decodeOut.regWrite || decodeOut.memWrite ||
                               decodeOut.branch || decodeOut.jump))
        else begin
            failCount++;
            $error("write, branch or jump enable high on an invalid decode");
        end

endmodule

bind frontEnd frontEndProps props (
    .clk       (clk),
    .rstN      (rstN),
    .redirect  (redirect),
    .stallF    (stallF),
    .pcF       (pcF),
    .decodeOut (decodeOut)
);

//--- logic/frontEnd.sv
`timescale 1ns/1ns

module frontEnd (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvPkg::redirectT        redirect,    // from execute
    input  logic                   stallF,      // hazard unit levels
    input  logic                   stallD,
    input  logic                   flushD,
    input  rvPkg::writebackT       wb,          // from writeback
    output logic [rvPkg::xlen-1:0] pcF,
    output rvPkg::decodeOutT       decodeOut
);

    rvPkg::instrWordT       instrF;         // ROM word at pcF
    rvPkg::fetchDecodeT     fetchDecode;    // fetch-to-decode register
    rvPkg::regAddrT         rs1D;           // decoder to register file
    rvPkg::regAddrT         rs2D;
    logic [rvPkg::xlen-1:0] rd1D;           // register file to decoder
    logic [rvPkg::xlen-1:0] rd2D;

    fetchStage uFetch (
        .clk         (clk),
        .rstN        (rstN),
        .stallF      (stallF),
        .stallD      (stallD),
        .flushD      (flushD),
        .redirect    (redirect),
        .instrF      (instrF),
        .pcF         (pcF),
        .fetchDecode (fetchDecode)
    );

    instructionMemory uImem (
        .addr  (pcF),
        .instr (instrF)
    );

    instructionDecoder uDecoder (
        .fetchDecode (fetchDecode),
        .rd1         (rd1D),
        .rd2         (rd2D),
        .rs1         (rs1D),
        .rs2         (rs2D),
        .decodeOut   (decodeOut)
    );

    registerFile uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .rs1  (rs1D),
        .rs2  (rs2D),
        .wb   (wb),
        .rd1  (rd1D),
        .rd2  (rd2D)
    );

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvPkg::regAddrT         rs1,
    input  rvPkg::regAddrT         rs2,
    input  rvPkg::writebackT       wb,      // from the writeback stage
    output logic [rvPkg::xlen-1:0] rd1,
    output logic [rvPkg::xlen-1:0] rd2
);

    logic [rvPkg::xlen-1:0] regs [1:rvPkg::regCount-1]; // x0 has no storage

    // one read port, with same-cycle bypass from wb
    function automatic logic [rvPkg::xlen-1:0] readPort(input rvPkg::regAddrT addr);
        if (addr == '0) begin
            return '0;                          // x0 hardwired
        end
        if (wb.regWrite && (wb.rd == addr)) begin
            return wb.result;                   // write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < rvPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.result;           // writes to x0 dropped
        end
    end

    always_comb begin
        rd1 = readPort(rs1);
        rd2 = readPort(rs2);
    end

endmodule

//--- logic/instructionDecoder.sv
`timescale 1ns/1ns

module instructionDecoder (
    input  rvPkg::fetchDecodeT     fetchDecode,
    input  logic [rvPkg::xlen-1:0] rd1,         // register file port a
    input  logic [rvPkg::xlen-1:0] rd2,         // register file port b
    output rvPkg::regAddrT         rs1,
    output rvPkg::regAddrT         rs2,
    output rvPkg::decodeOutT       decodeOut
);

    rvPkg::instrWordT instr;    // word held in the decode stage

    assign instr = fetchDecode.instr;

    // source fields sit at the same bits in every format that has them
    assign rs1 = instr.rFmt.rs1;
    assign rs2 = instr.rFmt.rs2;

    always_comb begin
        rvPkg::immSrcT immSrc;      // immediate layout for this opcode
        logic          regWriteRaw; // enables before valid gating
        logic          memWriteRaw;
        logic          branchRaw;
        logic          jumpRaw;

        immSrc      = rvPkg::immI;
        regWriteRaw = 1'b0;
        memWriteRaw = 1'b0;
        branchRaw   = 1'b0;
        jumpRaw     = 1'b0;
        decodeOut   = '0;

        decodeOut.resultSrc  = rvPkg::resAluResult;
        decodeOut.aluControl = rvPkg::aluAdd;

        case (instr.rFmt.opcode)
            rvPkg::opOpImm: begin
                regWriteRaw      = 1'b1;
                decodeOut.aluSrc = 1'b1;                        // rs1 op imm
                if (instr.iFmt.funct3 == rvPkg::f3Sll) begin
                    decodeOut.aluControl = rvPkg::aluSll;       // slli
                end
            end
            rvPkg::opOp: begin
                regWriteRaw = 1'b1;
                if (instr.rFmt.funct7[5]) begin
                    decodeOut.aluControl = rvPkg::aluSub;       // sub
                end
            end
            rvPkg::opLoad: begin
                regWriteRaw         = 1'b1;
                decodeOut.aluSrc    = 1'b1;                     // base plus offset
                decodeOut.resultSrc = rvPkg::resMemData;
            end
            rvPkg::opStore: begin
                memWriteRaw      = 1'b1;
                decodeOut.aluSrc = 1'b1;
                immSrc           = rvPkg::immS;
            end
            rvPkg::opBranch: begin
                branchRaw = 1'b1;
                immSrc    = rvPkg::immB;
                if (instr.bFmt.funct3 == rvPkg::f3Blt) begin
                    decodeOut.aluControl = rvPkg::aluLessThan;  // blt
                end else begin
                    decodeOut.aluControl = rvPkg::aluSub;       // beq compares by zero
                end
            end
            rvPkg::opJal: begin
                jumpRaw             = 1'b1;
                regWriteRaw         = 1'b1;                     // link register
                decodeOut.resultSrc = rvPkg::resPcPlus4;
                immSrc              = rvPkg::immJ;
            end
            default: begin
                decodeOut.illegal = 1'b1;                       // enables stay low
            end
        endcase

        // sign extension per format
        case (immSrc)
            rvPkg::immS: decodeOut.immExt = {{20{instr.sFmt.imm11_5[6]}},
                                             instr.sFmt.imm11_5, instr.sFmt.imm4_0};
            rvPkg::immB: decodeOut.immExt = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12,
                                             instr.bFmt.imm11, instr.bFmt.imm10_5,
                                             instr.bFmt.imm4_1, 1'b0};
            rvPkg::immJ: decodeOut.immExt = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20,
                                             instr.jFmt.imm19_12, instr.jFmt.imm11,
                                             instr.jFmt.imm10_1, 1'b0};
            default:     decodeOut.immExt = {{20{instr.iFmt.imm11_0[11]}},
                                             instr.iFmt.imm11_0};
        endcase

        // a bubble must not write or redirect anything
        decodeOut.regWrite = regWriteRaw & fetchDecode.valid;
        decodeOut.memWrite = memWriteRaw & fetchDecode.valid;
        decodeOut.branch   = branchRaw & fetchDecode.valid;
        decodeOut.jump     = jumpRaw & fetchDecode.valid;

        decodeOut.funct3  = instr.rFmt.funct3;  // execute picks the branch condition
        decodeOut.rs1     = rs1;
        decodeOut.rs2     = rs2;
        decodeOut.rd      = instr.rFmt.rd;
        decodeOut.rd1     = rd1;
        decodeOut.rd2     = rd2;
        decodeOut.pc      = fetchDecode.pc;
        decodeOut.pcPlus4 = fetchDecode.pcPlus4;
        decodeOut.valid   = fetchDecode.valid;
    end

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/1ns

module fetchStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stallF,      // hold pc
    input  logic                   stallD,      // hold fetch-to-decode register
    input  logic                   flushD,      // squash fetch-to-decode register
    input  rvPkg::redirectT        redirect,
    input  rvPkg::instrWordT       instrF,      // word at pcF from the ROM
    output logic [rvPkg::xlen-1:0] pcF,
    output rvPkg::fetchDecodeT     fetchDecode
);

    logic [rvPkg::xlen-1:0] pcPlus4F;   // sequential address
    logic [rvPkg::xlen-1:0] pcNext;     // address loaded at the next edge

    assign pcPlus4F = pcF + 32'd4;

    // redirect from execute wins over the sequential path
    assign pcNext = redirect.pcSrc ? redirect.target : pcPlus4F;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcF <= '0;                  // boot address
        end else if (!stallF) begin
            pcF <= pcNext;
        end
    end

    // fetch-to-decode register
    // flush before stall, reset shares the bubble path
    always_ff @(posedge clk) begin
        if (!rstN || flushD) begin
            fetchDecode.instr   <= rvPkg::nopWord;  // bubble
            fetchDecode.pc      <= '0;
            fetchDecode.pcPlus4 <= '0;
            fetchDecode.valid   <= 1'b0;
        end else if (!stallD) begin
            fetchDecode.instr   <= instrF;
            fetchDecode.pc      <= pcF;
            fetchDecode.pcPlus4 <= pcPlus4F;
            fetchDecode.valid   <= 1'b1;
        end
    end

endmodule

//--- logic/instructionMemory.sv
`timescale 1ns/1ns

module instructionMemory (
    input  logic [rvPkg::xlen-1:0] addr,    // fetch pc, byte address
    output rvPkg::instrWordT       instr
);

    logic [rvPkg::xlen-1:0] rom [0:rvPkg::imemDepth-1]; // program words

    logic [rvPkg::imemAddrW-1:0] wordIdx;   // pc[9:2], byte offset dropped

    initial begin
        $readmemh("program.hex", rom);      // unused words hold nops in the file
    end

    assign wordIdx = addr[rvPkg::imemAddrW+1:2];

    // no clock, the word is valid in the same cycle as the pc
    assign instr = rom[wordIdx];

endmodule

//--- logic/rvPkg.sv
package rvPkg;

    localparam int xlen      = 32;                  // data and address width
    localparam int imemDepth = 256;                 // instruction words in the ROM
    localparam int imemAddrW = $clog2(imemDepth);   // word index bits, taken from pc[9:2]
    localparam int regCount  = 32;                  // architectural registers x0..x31

    localparam logic [xlen-1:0] nopWord = 32'h0000_0013; // addi x0, x0, 0

    // major opcodes of the supported subset
    localparam logic [6:0] opLoad   = 7'b0000011;   // lw
    localparam logic [6:0] opStore  = 7'b0100011;   // sw
    localparam logic [6:0] opBranch = 7'b1100011;   // beq, blt
    localparam logic [6:0] opJal    = 7'b1101111;   // jal
    localparam logic [6:0] opOpImm  = 7'b0010011;   // addi, slli
    localparam logic [6:0] opOp     = 7'b0110011;   // add, sub

    localparam logic [2:0] f3Sll = 3'b001;          // slli inside op-imm
    localparam logic [2:0] f3Blt = 3'b100;          // blt inside branch

    typedef logic [$clog2(regCount)-1:0] regAddrT;

    // instruction formats, fields listed msb first
    typedef struct packed {
        logic [6:0] funct7;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        regAddrT    rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm11_0;
        regAddrT     rs1;
        logic [2:0]  funct3;
        regAddrT     rd;
        logic [6:0]  opcode;
    } iFmtT;

    typedef struct packed {
        logic [6:0] imm11_5;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sFmtT;

    typedef struct packed {
        logic       imm12;      // sign bit
        logic [5:0] imm10_5;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;      // sits where rd[0] would be
        logic [6:0] opcode;
    } bFmtT;

    typedef struct packed {
        logic       imm20;      // sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        regAddrT    rd;
        logic [6:0] opcode;
    } jFmtT;

    // one fetched word, five ways to look at it
    typedef union packed {
        logic [xlen-1:0] raw;
        rFmtT            rFmt;
        iFmtT            iFmt;
        sFmtT            sFmt;
        bFmtT            bFmt;
        jFmtT            jFmt;
    } instrWordT;

    typedef enum logic [2:0] {immI, immS, immB, immJ} immSrcT;
    typedef enum logic [2:0] {aluAdd, aluSub, aluSll, aluLessThan} aluCtrlT;
    typedef enum logic [1:0] {resAluResult, resMemData, resPcPlus4} resultSrcT;

    typedef struct packed {
        logic            pcSrc;     // taken branch or jump in execute
        logic [xlen-1:0] target;
    } redirectT;

    typedef struct packed {
        logic            regWrite;
        regAddrT         rd;
        logic [xlen-1:0] result;
    } writebackT;

    typedef struct packed {
        instrWordT       instr;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pcPlus4;
        logic            valid;     // low for bubbles after reset or flush
    } fetchDecodeT;

    typedef struct packed {
        logic            regWrite;
        logic            memWrite;
        logic            branch;
        logic            jump;
        logic            aluSrc;    // high selects immExt as alu operand b
        logic            illegal;
        resultSrcT       resultSrc;
        aluCtrlT         aluControl;
        logic [2:0]      funct3;
        regAddrT         rs1;
        regAddrT         rs2;
        regAddrT         rd;
        logic [xlen-1:0] rd1;
        logic [xlen-1:0] rd2;
        logic [xlen-1:0] immExt;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pcPlus4;
        logic            valid;
    } decodeOutT;

endpackage
